/* src/decode_cfg.svh */
/*
	Decode stage configuration
	Word, register file and opcode sizes shared by the package and
	the decode RTL, plus the register used by jump-and-link.
*/
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// Datapath word
`define WORD_WIDTH 16

// Register file geometry
`define NUM_REGS 8
`define REG_IDX_WIDTH 3

// Major opcode, instruction bits 15..11
`define OPCODE_WIDTH 5

// R7 receives the return address
`define LINK_REG 7

`endif

/* src/decodePkg.sv */
/*
	Decode package
	Field typedefs, control encodings and the grouped control bundles
	passed from the decode stage to execute, memory and fetch.
*/
`include "decode_cfg.svh"

package decodePkg;

	typedef logic [`WORD_WIDTH-1:0] word;
	typedef logic [`REG_IDX_WIDTH-1:0] regIdx;
	typedef logic [`OPCODE_WIDTH-1:0] opCode;
	typedef logic [1:0] funct;			// Instruction bits 1..0

	// Order fixes the encoding seen by the ALU
	typedef enum logic [2:0] {
		aluRol, aluSll, aluSra, aluSrl,
		aluAdd, aluAnd, aluOr, aluXor
	} aluOpE;

	typedef enum logic [1:0] {cmpEq, cmpLt, cmpLe, cmpCo} cmpOpE;

	// Results the ALU alone cannot form
	typedef enum logic [1:0] {specNone, specBtr, specLbi, specSlbi} specialOpE;

	// Write register source: bits 10..8, 7..5, 4..2 or the link register
	typedef enum logic [1:0] {dstRs, dstRt, dstRd, dstLink} regDstE;

	typedef struct packed {
		aluOpE aluOp;
		logic aluSrc;		// Operand B from immediate
		logic clrAluSrc;	// Operand B forced to zero
		logic cin;
		logic invA;
		logic invB;
	} aluCtrlT;

	typedef struct packed {
		logic memRead;
		logic memWrite;
		logic memToReg;
	} memCtrlT;

	typedef struct packed {
		logic halt;
		logic createDump;
		logic jumpI;		// Register-relative jump
		logic jumpD;		// PC-relative jump
		logic link;
	} flowCtrlT;

	typedef struct packed {
		logic cmpSet;
		cmpOpE cmpOp;
	} cmpCtrlT;

endpackage

/* src/regFile.sv */
/*
	Register file
	Eight words with two combinational read ports and one write port
	that updates on the rising clock edge. Reset clears every entry.
	A read in the same cycle as a write sees the old value.
*/
`timescale 1ns/1ps
`include "decode_cfg.svh"

module regFile (
	input logic clk,
	input logic rstN,
	input decodePkg::regIdx readSel1,
	input decodePkg::regIdx readSel2,
	input decodePkg::regIdx writeSel,
	input decodePkg::word writeData,
	input logic writeEn,
	output decodePkg::word readData1,
	output decodePkg::word readData2
);

	decodePkg::word regs [`NUM_REGS];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeSel] <= writeData;
		end
	end

	// No write bypass
	assign readData1 = regs[readSel1];
	assign readData2 = regs[readSel2];

endmodule

/* src/control.sv */
/*
	Control unit
	Decodes the major opcode and function field into the ALU, memory,
	flow and compare bundles, the write register source and the
	immediate form. Opcodes outside the instruction set raise illegal.
*/
`timescale 1ns/1ps

module control (
	input decodePkg::opCode op,
	input decodePkg::funct fn,
	output decodePkg::aluCtrlT aluCtrl,
	output decodePkg::memCtrlT memCtrl,
	output decodePkg::flowCtrlT flowCtrl,
	output decodePkg::cmpCtrlT cmpCtrl,
	output decodePkg::specialOpE specialOp,
	output decodePkg::regDstE regDst,
	output logic regWrite,
	output logic imm5,
	output logic signImm,
	output logic branch,
	output logic illegal
);

	decodePkg::funct subOp;

	// Register forms 1101x take the sub-operation from fn, immediates from op
	assign subOp = (op[4] & op[3]) ? fn : op[1:0];

	always_comb begin
		aluCtrl = '0;
		memCtrl = '0;
		flowCtrl = '0;
		cmpCtrl = '0;
		specialOp = decodePkg::specNone;
		regDst = decodePkg::dstRs;
		regWrite = 1'b0;
		imm5 = 1'b0;
		signImm = 1'b0;
		branch = 1'b0;
		illegal = 1'b0;

		casez (op)
			5'b00000: flowCtrl.halt = 1'b1;
			5'b00001: begin
				// NOP
			end
			5'b00010: flowCtrl.createDump = 1'b1;
			5'b00100: flowCtrl.jumpD = 1'b1;		// J
			5'b00101, 5'b00111: begin			// JR, JALR
				flowCtrl.jumpI = 1'b1;
				aluCtrl.aluOp = decodePkg::aluAdd;
				aluCtrl.aluSrc = 1'b1;
				signImm = 1'b1;
				if (op[1]) begin
					flowCtrl.link = 1'b1;
					regWrite = 1'b1;
					regDst = decodePkg::dstLink;
				end
			end
			5'b00110: begin				// JAL
				flowCtrl.jumpD = 1'b1;
				flowCtrl.link = 1'b1;
				regWrite = 1'b1;
				regDst = decodePkg::dstLink;
			end
			5'b010??, 5'b11011: begin		// ADDI..ANDNI and ADD..ANDN
				aluCtrl.aluSrc = ~op[4];
				imm5 = ~op[4];
				regWrite = 1'b1;
				regDst = op[4] ? decodePkg::dstRd : decodePkg::dstRt;
				case (subOp)
					2'b00: begin
						aluCtrl.aluOp = decodePkg::aluAdd;
						signImm = ~op[4];
					end
					2'b01: begin			// Second operand minus Rs
						aluCtrl.aluOp = decodePkg::aluAdd;
						aluCtrl.invA = 1'b1;
						aluCtrl.cin = 1'b1;
						signImm = ~op[4];
					end
					2'b10: aluCtrl.aluOp = decodePkg::aluXor;
					2'b11: begin
						aluCtrl.aluOp = decodePkg::aluAnd;
						aluCtrl.invB = 1'b1;
					end
				endcase
			end
			5'b011??: begin				// Branches, ALU passes Rs through
				branch = 1'b1;
				signImm = 1'b1;
				aluCtrl.clrAluSrc = 1'b1;
			end
			5'b1000?, 5'b10011: begin		// ST, LD, STU
				aluCtrl.aluOp = decodePkg::aluAdd;
				aluCtrl.aluSrc = 1'b1;
				imm5 = 1'b1;
				signImm = 1'b1;
				memCtrl.memWrite = ~op[0] | op[1];
				if (op == 5'b10001) begin
					memCtrl.memRead = 1'b1;
					memCtrl.memToReg = 1'b1;
					regWrite = 1'b1;
					regDst = decodePkg::dstRt;
				end else if (op[1]) begin
					regWrite = 1'b1;		// STU updates the base
					regDst = decodePkg::dstRs;
				end
			end
			5'b10010: begin				// SLBI
				specialOp = decodePkg::specSlbi;
				aluCtrl.aluSrc = 1'b1;
				regWrite = 1'b1;
				regDst = decodePkg::dstRs;
			end
			5'b101??, 5'b11010: begin		// Shift and rotate
				aluCtrl.aluOp = decodePkg::aluOpE'({1'b0, subOp});
				aluCtrl.aluSrc = ~op[3];
				imm5 = ~op[3];
				regWrite = 1'b1;
				regDst = op[3] ? decodePkg::dstRd : decodePkg::dstRt;
			end
			5'b11000: begin				// LBI
				specialOp = decodePkg::specLbi;
				aluCtrl.aluSrc = 1'b1;
				signImm = 1'b1;
				regWrite = 1'b1;
				regDst = decodePkg::dstRs;
			end
			5'b11001: begin				// BTR
				specialOp = decodePkg::specBtr;
				aluCtrl.clrAluSrc = 1'b1;
				regWrite = 1'b1;
				regDst = decodePkg::dstRd;
			end
			5'b111??: begin				// SEQ, SLT, SLE, SCO
				cmpCtrl.cmpSet = 1'b1;
				cmpCtrl.cmpOp = decodePkg::cmpOpE'(op[1:0]);
				aluCtrl.aluOp = decodePkg::aluAdd;
				aluCtrl.invB = ~(op[1] & op[0]);	// Rs - Rt except carry-out
				aluCtrl.cin = ~(op[1] & op[0]);
				regWrite = 1'b1;
				regDst = decodePkg::dstRd;
			end
			default: illegal = 1'b1;
		endcase
	end

endmodule

/* src/branchUnit.sv */
/*
	Branch unit
	Tests Rs against zero or its sign as selected by the low opcode
	bits and forms the PC-relative target from the 8-bit offset.
*/
`timescale 1ns/1ps
`include "decode_cfg.svh"

module branchUnit (
	input logic [1:0] brOp,
	input decodePkg::word rs,
	input logic [7:0] imm8,
	input decodePkg::word pcPlusTwo,
	output logic cond,
	output decodePkg::word target
);

	logic isZero;
	logic isNeg;

	assign isZero = (rs == '0);
	assign isNeg = rs[`WORD_WIDTH-1];

	always_comb begin
		case (brOp)
			2'b00: cond = isZero;		// BEQZ
			2'b01: cond = ~isZero;		// BNEZ
			2'b10: cond = isNeg;		// BLTZ
			default: cond = ~isNeg;		// BGEZ
		endcase
	end

	// Formed for every opcode, used only when the branch is taken
	assign target = pcPlusTwo + {{(`WORD_WIDTH-8){imm8[7]}}, imm8};

endmodule

/* src/decode.sv */
/*
	Decode stage
	Reads both source registers, writes back the incoming result,
	decodes the control bundles and extends the immediate. Branch
	condition and target are resolved here. err flags opcodes outside
	the instruction set.
*/
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode (
	input logic clk,
	input logic rstN,
	input decodePkg::word instr,
	input decodePkg::word wbData,
	input decodePkg::word pcPlusTwo,
	output decodePkg::word readData1,
	output decodePkg::word readData2,
	output decodePkg::word immExt,
	output decodePkg::aluCtrlT aluCtrl,
	output decodePkg::memCtrlT memCtrl,
	output decodePkg::flowCtrlT flowCtrl,
	output decodePkg::cmpCtrlT cmpCtrl,
	output decodePkg::specialOpE specialOp,
	output logic branchTaken,
	output decodePkg::word branchTarget,
	output logic err
);

	decodePkg::opCode op;
	decodePkg::funct fn;
	decodePkg::regIdx rsIdx, rtIdx, rdIdx;
	decodePkg::regIdx writeSel;
	decodePkg::regDstE regDst;
	logic regWrite, imm5, signImm, branch, illegal;
	logic cond;

	assign op = instr[`WORD_WIDTH-1 -: `OPCODE_WIDTH];
	assign fn = instr[1:0];
	assign rsIdx = instr[10:8];
	assign rtIdx = instr[7:5];
	assign rdIdx = instr[4:2];

	always_comb begin
		case (regDst)
			decodePkg::dstRs: writeSel = rsIdx;
			decodePkg::dstRt: writeSel = rtIdx;
			decodePkg::dstRd: writeSel = rdIdx;
			default: writeSel = decodePkg::regIdx'(`LINK_REG);
		endcase
	end

	regFile regs (
		.clk(clk),
		.rstN(rstN),
		.readSel1(rsIdx),
		.readSel2(rtIdx),
		.writeSel(writeSel),
		.writeData(wbData),
		.writeEn(regWrite),
		.readData1(readData1),
		.readData2(readData2)
	);

	control ctrl (
		.op(op),
		.fn(fn),
		.aluCtrl(aluCtrl),
		.memCtrl(memCtrl),
		.flowCtrl(flowCtrl),
		.cmpCtrl(cmpCtrl),
		.specialOp(specialOp),
		.regDst(regDst),
		.regWrite(regWrite),
		.imm5(imm5),
		.signImm(signImm),
		.branch(branch),
		.illegal(illegal)
	);

	// 5-bit or 8-bit field, extended from its own top bit
	always_comb begin
		if (imm5) begin
			immExt = {{(`WORD_WIDTH-5){signImm & instr[4]}}, instr[4:0]};
		end else begin
			immExt = {{(`WORD_WIDTH-8){signImm & instr[7]}}, instr[7:0]};
		end
	end

	branchUnit br (
		.brOp(op[1:0]),
		.rs(readData1),
		.imm8(instr[7:0]),
		.pcPlusTwo(pcPlusTwo),
		.cond(cond),
		.target(branchTarget)
	);

	assign branchTaken = branch & cond;
	assign err = illegal;

endmodule

/* bench/decodeTb.sv */
/*
	Decode stage testbench
	Replays the vectors of bench/decode_input.txt through the decode
	stage, one per clock, and checks the output each vector selects.
*/
`timescale 1ns/1ps

module decodeTb;

	logic clk;
	logic rstN;
	decodePkg::word instr, wbData, pcPlusTwo;
	decodePkg::word readData1, readData2, immExt, branchTarget;
	decodePkg::aluCtrlT aluCtrl;
	decodePkg::memCtrlT memCtrl;
	decodePkg::flowCtrlT flowCtrl;
	decodePkg::cmpCtrlT cmpCtrl;
	decodePkg::specialOpE specialOp;
	logic branchTaken, err;

	int testQ[$];
	string kindQ[$];
	decodePkg::word instrQ[$], wbQ[$], pcQ[$], expQ[$];
	int errors = 0;
	int passes = 0;
	int checks = 0;
	int testErrors = 0;
	int curTest = 0;
	int cycles = 0;
	int limit = 1000;
	decodePkg::word padInstr [3] = '{16'h0800, 16'h1000, 16'h2000};	// NOP, dump, J

	decode DUT (
		.clk(clk), .rstN(rstN),
		.instr(instr), .wbData(wbData), .pcPlusTwo(pcPlusTwo),
		.readData1(readData1), .readData2(readData2), .immExt(immExt),
		.aluCtrl(aluCtrl), .memCtrl(memCtrl), .flowCtrl(flowCtrl), .cmpCtrl(cmpCtrl),
		.specialOp(specialOp), .branchTaken(branchTaken),
		.branchTarget(branchTarget), .err(err)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
	end

	initial begin
		wait (cycles > limit);
		$display("Run stopped after %0d cycles without finishing", cycles);
		$display("Test failed");
		$finish;
	end

	task automatic noteResult(input logic ok, input string msg);
		checks++;
		if (ok) begin
			passes++;
		end else begin
			errors++;
			testErrors++;
			$display("[ERROR] %0t: test %0d %s", $time, curTest, msg);
		end
	endtask

	task automatic compareWord(input decodePkg::word got, input decodePkg::word exp,
			input string what);
		noteResult(got === exp, $sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic compareAlu(input decodePkg::aluCtrlT got, input decodePkg::aluCtrlT exp);
		noteResult(got === exp, $sformatf("aluCtrl got %h expected %h", got, exp));
	endtask

	task automatic compareMem(input decodePkg::memCtrlT got, input decodePkg::memCtrlT exp);
		noteResult(got === exp, $sformatf("memCtrl got %b expected %b", got, exp));
	endtask

	task automatic compareFlow(input decodePkg::flowCtrlT got, input decodePkg::flowCtrlT exp);
		noteResult(got === exp, $sformatf("flowCtrl got %b expected %b", got, exp));
	endtask

	task automatic compareCmp(input decodePkg::cmpCtrlT got, input decodePkg::cmpCtrlT exp);
		noteResult(got === exp, $sformatf("cmpCtrl got %b expected %b", got, exp));
	endtask

	task automatic compareSpecial(input decodePkg::specialOpE got,
			input decodePkg::specialOpE exp);
		noteResult(got === exp, $sformatf("specialOp got %s expected %s", got.name(), exp.name()));
	endtask

	task automatic compareBit(input logic got, input logic exp, input string what);
		noteResult(got === exp, $sformatf("%s got %b expected %b", what, got, exp));
	endtask

	task automatic loadVectors(output bit opened);
		int fd;
		int num;
		string line, kind;
		decodePkg::word a, b, c, e;
		opened = 1'b0;
		fd = $fopen("bench/decode_input.txt", "r");
		if (fd != 0) begin
			opened = 1'b1;
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// Comment and blank lines do not parse
				if ($sscanf(line, "%d %s %h %h %h %h", num, kind, a, b, c, e) == 6) begin
					testQ.push_back(num);
					kindQ.push_back(kind);
					instrQ.push_back(a);
					wbQ.push_back(b);
					pcQ.push_back(c);
					expQ.push_back(e);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic checkVector(input string kind, input decodePkg::word exp);
		case (kind)
			"rd1": compareWord(readData1, exp, "readData1");
			"rd2": compareWord(readData2, exp, "readData2");
			"imm": compareWord(immExt, exp, "immExt");
			"tgt": compareWord(branchTarget, exp, "branchTarget");
			"alu": compareAlu(aluCtrl, decodePkg::aluCtrlT'(exp[7:0]));
			"mem": compareMem(memCtrl, decodePkg::memCtrlT'(exp[2:0]));
			"flow": compareFlow(flowCtrl, decodePkg::flowCtrlT'(exp[4:0]));
			"cmp": compareCmp(cmpCtrl, decodePkg::cmpCtrlT'(exp[2:0]));
			"spec": compareSpecial(specialOp, decodePkg::specialOpE'(exp[1:0]));
			"take": compareBit(branchTaken, exp[0], "branchTaken");
			"err": compareBit(err, exp[0], "err");
			default: begin
				errors++;
				testErrors++;
				$display("A vector of test %0d has the unknown kind tag %s", curTest, kind);
			end
		endcase
	endtask

	task automatic finishTest();
		$display("Group %0d: %s", curTest, (testErrors == 0) ? "ok" : "FAILED");
	endtask

	task automatic runVectors();
		if (testQ.size() > 0) curTest = testQ[0];
		foreach (testQ[i]) begin
			if (testQ[i] != curTest) begin
				finishTest();
				curTest = testQ[i];
				testErrors = 0;
				@(negedge clk);
				instr = padInstr[$urandom % 3];	// Idle cycle, writes nothing
			end
			@(negedge clk);
			instr = instrQ[i];
			wbData = wbQ[i];
			pcPlusTwo = pcQ[i];
			#1.5;		// Just ahead of the write edge
			checkVector(kindQ[i], expQ[i]);
		end
		finishTest();
	endtask

	initial begin
		bit opened;
		void'($urandom(32'h151f));
		rstN = 1'b0;
		instr = '0;
		wbData = '0;
		pcPlusTwo = '0;
		loadVectors(opened);
		if (!opened) begin
			$display("The vector file bench/decode_input.txt could not be opened");
			$display("Test failed");
		end else begin
			limit = 4 * testQ.size() + 20;
			repeat (2) @(posedge clk);
			@(negedge clk);
			rstN = 1'b1;
			runVectors();
			$display("Checks passed: %0d, checks failed: %0d", passes, errors);
			if (errors == 0 && checks > 0) begin
				$display("Test passed");
			end else begin
				$display("Test failed");
			end
		end
		$finish;
	end

endmodule

/* verilog.f */
+incdir+src
src/decodePkg.sv
src/regFile.sv
src/control.sv
src/branchUnit.sv
src/decode.sv
bench/decodeTb.sv

/* bench/decode_input.txt */
# test kind instr wbData pcPlusTwo expected (all hex except test)
# kind selects the output: rd1 rd2 imm tgt alu mem flow cmp spec take err
1 rd1 0BA0 0000 0000 0000
1 rd2 0BA0 0000 0000 0000
1 rd1 0FC0 0000 0000 0000
1 rd2 0FC0 0000 0000 0000
2 rd1 D904 1234 0000 0000
2 rd1 0900 0000 0000 1234
2 rd2 4243 ABCD 0000 0000
2 rd2 0840 0000 0000 ABCD
2 rd1 C455 0055 0000 0000
2 rd1 0C00 0000 0000 0055
2 rd1 3700 0102 0000 0000
2 rd1 0F00 0000 0000 0102
3 imm 400F 0000 0000 000F
3 imm 4013 0000 0000 FFF3
3 imm 5013 0000 0000 0013
3 imm 8010 0000 0000 FFF0
3 imm C080 0000 0000 FF80
3 imm 90F0 0000 0000 00F0
4 flow 0000 0000 0000 0010
4 alu 0000 0000 0000 0000
4 alu D801 0000 0000 0086
4 alu D803 0000 0000 00A1
4 alu 4800 0000 0000 0096
4 alu B000 0000 0000 0050
4 mem 8800 0000 0000 0005
4 mem 9800 0000 0000 0002
4 spec 9000 0000 0000 0003
4 spec C800 0000 0000 0001
4 flow 3800 0000 0000 0005
4 flow 3000 0000 0000 0003
4 cmp E000 0000 0000 0004
4 cmp F800 0000 0000 0007
5 rd1 C500 0042 0000 0000
5 rd1 C600 8001 0000 0000
5 take 6010 0000 0100 0001
5 tgt 6010 0000 0100 0110
5 take 6D10 0000 0100 0001
5 take 6810 0000 0100 0000
5 take 76F0 0000 0100 0001
5 tgt 76F0 0000 0100 00F0
5 take 75F0 0000 0100 0000
5 take 7E7F 0000 0200 0000
5 take 787F 0000 0200 0001
5 take 0D10 0000 0100 0000
6 err 1800 0000 0000 0001
6 err 0000 0000 0000 0000
6 err D800 0000 0000 0000
6 err 6000 0000 0000 0000
